// File: common/vic_params.svh
`ifndef VIC_PARAMS_SVH
`define VIC_PARAMS_SVH

// ----------------------------------------------------------------------
// Host download indices
// ----------------------------------------------------------------------

// ROM image data
`define VIC_IDX_ROM 8'd0
// Game mode select, low 5 bits of the data
`define VIC_IDX_MODE 8'd1
// DIP switch banks, bank number in address bits 2:0
`define VIC_IDX_DIP 8'd254

// Number of stored DIP banks
`define VIC_DIP_BANKS 8

// Active-low input port with nothing pressed
`define VIC_PORT_IDLE 8'hFF

// ----------------------------------------------------------------------
// Status word bit positions
// ----------------------------------------------------------------------

`define VIC_ST_RESET 0
`define VIC_ST_HORZ 2
// Aspect select occupies this bit and the one above
`define VIC_ST_AR_LO 8

// Space Attack lives codes as seen by the game CPU
`define VIC_SA_LIVES_3 3'd3
`define VIC_SA_LIVES_4 3'd4
`define VIC_SA_LIVES_5 3'd5
`define VIC_SA_LIVES_6 3'd6

`endif

// File: common/vic_pkg.sv
package vic_pkg;

	// One active-low CPU input port
	typedef logic [7:0] port_byte_t;

	// One DIP switch bank
	typedef logic [7:0] dip_bank_t;

	// Joystick buttons
	// 0..3 right/left/down/up, 4..6 fire 1..3, 7 start 1, 8 start 2, 9 coin
	typedef logic [11:0] joy_t;

	// ------------------------------------------------------------------
	// Host download bus
	// ------------------------------------------------------------------

	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_bus_t;

	// ------------------------------------------------------------------
	// Player controls, active high
	// ------------------------------------------------------------------

	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire1;
		logic fire2;
		logic fire3;
	} player_ctrl_t;

	typedef struct packed {
		player_ctrl_t p1;
		player_ctrl_t p2;
		logic         start_p1;
		logic         start_p2;
		logic         coin;
	} ctrl_set_t;

	// The four ports read by the game CPU
	typedef struct packed {
		port_byte_t p1;
		port_byte_t p2;
		port_byte_t p3;
		port_byte_t p4;
	} in_ports_t;

	// Supported games; other codes select nothing
	typedef enum logic [4:0] {
		GAME_CARNIVAL    = 5'd3,
		GAME_DIGGER      = 5'd4,
		GAME_FROGS       = 5'd5,
		GAME_HEADON      = 5'd6,
		GAME_HEIANKYO    = 5'd8,
		GAME_SPACEATTACK = 5'd16
	} game_id_t;

endpackage

// File: src/download_ctrl.sv
`timescale 1ns/1ps

`include "vic_params.svh"

module download_ctrl
	import vic_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,
	input  dl_bus_t     dl,
	input  logic [31:0] status,
	input  logic        user_reset,
	output game_id_t    game_mode,
	output dip_bank_t   dip0,
	output logic        core_reset
);

	logic wr_en;
	logic mode_wr;
	logic dip_wr;
	logic rom_wr;
	logic rom_download;
	logic rom_loaded;

	dip_bank_t dip_banks [`VIC_DIP_BANKS];

	// ------------------------------------------------------------------
	// Write decode
	// ------------------------------------------------------------------

	assign wr_en = dl.download && dl.wr;
	assign mode_wr = wr_en && (dl.index == `VIC_IDX_MODE);
	// Only the first eight addresses map to banks
	assign dip_wr = wr_en && (dl.index == `VIC_IDX_DIP) && (dl.addr[24:3] == 22'd0);
	assign rom_wr = wr_en && (dl.index == `VIC_IDX_ROM);

	// Held for the whole ROM transfer, not just on strobes
	assign rom_download = dl.download && (dl.index == `VIC_IDX_ROM);

	// ------------------------------------------------------------------
	// Configuration registers
	// ------------------------------------------------------------------

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			game_mode <= game_id_t'(5'd0);
			rom_loaded <= 1'b0;
			for (int i = 0; i < `VIC_DIP_BANKS; i++)
			begin
				dip_banks[i] <= '0;
			end
		end
		else
		begin
			if (mode_wr)
			begin
				game_mode <= game_id_t'(dl.data[4:0]);
			end
			if (dip_wr)
			begin
				dip_banks[dl.addr[2:0]] <= dl.data;
			end
			// A blank image leaves the core held in reset
			if (rom_wr && (dl.data != 8'd0))
			begin
				rom_loaded <= 1'b1;
			end
		end
	end

	// Kept games only decode the first bank
	assign dip0 = dip_banks[0];

	// ------------------------------------------------------------------
	// Core reset
	// ------------------------------------------------------------------

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			core_reset <= 1'b1;
		end
		else
		begin
			core_reset <= status[`VIC_ST_RESET] | user_reset | rom_download | ~rom_loaded;
		end
	end

	// No game runs until ROM data has arrived
	assert property (@(posedge clk_sys) !rom_loaded |=> core_reset);

	// Mode register moves only on a host mode write
	assert property (@(posedge clk_sys) disable iff (rst)
		(game_mode != $past(game_mode)) |-> ($past(mode_wr) || $past(rst)));

endmodule

// File: port_map/player_router.sv
`timescale 1ns/1ps

module player_router
	import vic_pkg::*;
(
	input  joy_t      joy0,
	input  joy_t      joy1,
	input  logic      simul2p,
	output ctrl_set_t ctrls
);

	joy_t joy_or;

	// Map one joystick onto the direction and fire bits of a player
	function automatic player_ctrl_t to_player(joy_t j);
		player_ctrl_t p;
		p.right = j[0];
		p.left = j[1];
		p.down = j[2];
		p.up = j[3];
		p.fire1 = j[4];
		p.fire2 = j[5];
		p.fire3 = j[6];
		return p;
	endfunction

	// Either stick drives the shared controls
	assign joy_or = joy0 | joy1;

	// ------------------------------------------------------------------
	// Player routing
	// ------------------------------------------------------------------

	always_comb
	begin
		if (simul2p)
		begin
			// Separate sticks for simultaneous play
			ctrls.p1 = to_player(joy0);
			ctrls.p2 = to_player(joy1);
		end
		else
		begin
			ctrls.p1 = to_player(joy_or);
			ctrls.p2 = to_player(joy_or);
		end

		// Start 1 only from the first stick
		ctrls.start_p1 = joy0[7];
		ctrls.start_p2 = joy_or[8];
		ctrls.coin = joy_or[9];
	end

endmodule

// File: port_map/cabinet_mapper.sv
`timescale 1ns/1ps

`include "vic_params.svh"

module cabinet_mapper
	import vic_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,
	input  game_id_t    game_mode,
	input  dip_bank_t   dip0,
	input  ctrl_set_t   ctrls,
	input  logic [31:0] status,
	output in_ports_t   ports,
	output logic        landscape,
	output logic        simul2p,
	output logic [12:0] video_arx,
	output logic [12:0] video_ary
);

	in_ports_t    ports_nxt;
	logic         landscape_nxt;
	logic         simul2p_nxt;
	logic [12:0]  arx_nxt;
	logic [12:0]  ary_nxt;
	logic [2:0]   sa_lives;
	logic [1:0]   ar;
	logic         horz;
	player_ctrl_t p1;
	player_ctrl_t p2;

	assign p1 = ctrls.p1;
	assign p2 = ctrls.p2;

	// Space Attack lives switch to CPU code
	always_comb
	begin
		case (dip0[2:1])
			2'd0: sa_lives = `VIC_SA_LIVES_3;
			2'd1: sa_lives = `VIC_SA_LIVES_4;
			2'd2: sa_lives = `VIC_SA_LIVES_5;
			default: sa_lives = `VIC_SA_LIVES_6;
		endcase
	end

	// ------------------------------------------------------------------
	// Per-game port layout
	// ------------------------------------------------------------------

	always_comb
	begin
		ports_nxt.p1 = `VIC_PORT_IDLE;
		ports_nxt.p2 = `VIC_PORT_IDLE;
		ports_nxt.p3 = `VIC_PORT_IDLE;
		ports_nxt.p4 = `VIC_PORT_IDLE;
		landscape_nxt = 1'b0;
		simul2p_nxt = 1'b0;

		case (game_mode)
			GAME_CARNIVAL:
			begin
				// Bit 4 of P1 is demo sounds
				ports_nxt.p1 = {3'b111, dip0[0], 4'b1111};
				ports_nxt.p2 = {2'b11, ~p1.right, ~p1.left, 4'b1011};
				ports_nxt.p3 = {2'b11, ~p1.fire1, ~ctrls.start_p1, 4'b1111};
				ports_nxt.p4 = {2'b11, ~ctrls.start_p2, 5'b11111};
			end
			GAME_DIGGER:
			begin
				ports_nxt.p1 = ~{p1.up, p1.left, p1.down, p1.right,
					p1.fire2, p1.fire1, ctrls.start_p2, ctrls.start_p1};
				// Lives
				ports_nxt.p3 = {6'b111111, dip0[1:0]};
			end
			GAME_FROGS:
			begin
				// Coinage, game time, free game, demo sounds
				ports_nxt.p1 = {~p1.fire1, dip0[3], dip0[2], dip0[1], dip0[0],
					~p1.left, ~p1.up, ~p1.right};
				landscape_nxt = 1'b1;
			end
			GAME_HEADON:
			begin
				ports_nxt.p1 = {~p1.up, ~p1.left, ~p1.down, ~p1.right, ~p1.fire1,
					dip0[0], dip0[2:1]};
				landscape_nxt = 1'b1;
			end
			GAME_HEIANKYO:
			begin
				ports_nxt.p1 = {2'b11, ~p1.fire1, ~p1.up, dip0[0], 1'b1, ~p2.fire1, ~p2.up};
				ports_nxt.p2 = {2'b11, ~p1.fire2, ~p1.right, 2'b01, ~p2.fire2, ~p2.right};
				ports_nxt.p3 = {3'b110, ~p1.down, 3'b110, ~p2.down};
				ports_nxt.p4 = {2'b11, ~ctrls.start_p1, ~p1.left, 1'b1, dip0[1],
					~ctrls.start_p2, ~p2.left};
				// Alternating play when the switch is set
				simul2p_nxt = ~dip0[0];
			end
			GAME_SPACEATTACK:
			begin
				ports_nxt.p1 = {~p1.left, ~p2.left, ~p2.right, ~p2.fire1,
					~ctrls.start_p2, ~ctrls.start_p1, ~p1.fire1, ~p1.right};
				// Credits display, bonus life, lives, bonus for final UFO
				ports_nxt.p3 = {dip0[4], 2'b11, dip0[3], sa_lives, dip0[0]};
			end
			default:
			begin
				ports_nxt.p1 = `VIC_PORT_IDLE;
			end
		endcase
	end

	// ------------------------------------------------------------------
	// Aspect ratio
	// ------------------------------------------------------------------

	assign ar = status[`VIC_ST_AR_LO + 1:`VIC_ST_AR_LO];
	assign horz = status[`VIC_ST_HORZ] | landscape_nxt;

	always_comb
	begin
		if (ar == 2'd0)
		begin
			arx_nxt = horz ? 13'd8 : 13'd7;
			ary_nxt = horz ? 13'd7 : 13'd8;
		end
		else
		begin
			// Scaler presets, selected by index
			arx_nxt = {11'd0, ar} - 13'd1;
			ary_nxt = 13'd0;
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			ports <= {4{`VIC_PORT_IDLE}};
			landscape <= 1'b0;
			simul2p <= 1'b0;
		end
		else
		begin
			ports <= ports_nxt;
			landscape <= landscape_nxt;
			simul2p <= simul2p_nxt;
		end
	end

	always_ff @(posedge clk_sys)
	begin
		video_arx <= arx_nxt;
		video_ary <= ary_nxt;
	end

	// Idle through reset and while the cleared mode propagates
	assert property (@(posedge clk_sys)
		rst |=> (ports == {4{`VIC_PORT_IDLE}}) ##1 (ports == {4{`VIC_PORT_IDLE}}));

endmodule

// File: src/vic_input_top.sv
`timescale 1ns/1ps

module vic_input_top
	import vic_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,
	input  dl_bus_t     dl,
	input  joy_t        joy0,
	input  joy_t        joy1,
	input  logic [31:0] status,
	input  logic        user_reset,
	output in_ports_t   ports,
	output logic        coin,
	output logic        landscape,
	output logic [12:0] video_arx,
	output logic [12:0] video_ary,
	output logic        core_reset
);

	game_id_t  game_mode;
	dip_bank_t dip0;
	ctrl_set_t ctrls;
	logic      simul2p;

	// ------------------------------------------------------------------
	// Host configuration and reset
	// ------------------------------------------------------------------

	download_ctrl u_download_ctrl (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.dl         (dl),
		.status     (status),
		.user_reset (user_reset),
		.game_mode  (game_mode),
		.dip0       (dip0),
		.core_reset (core_reset)
	);

	// ------------------------------------------------------------------
	// Controls to CPU ports
	// ------------------------------------------------------------------

	player_router u_player_router (
		.joy0    (joy0),
		.joy1    (joy1),
		.simul2p (simul2p),
		.ctrls   (ctrls)
	);

	cabinet_mapper u_cabinet_mapper (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.game_mode (game_mode),
		.dip0      (dip0),
		.ctrls     (ctrls),
		.status    (status),
		.ports     (ports),
		.landscape (landscape),
		.simul2p   (simul2p),
		.video_arx (video_arx),
		.video_ary (video_ary)
	);

	// Coin goes to the game board directly
	assign coin = ctrls.coin;

endmodule

// File: test/tb_vic_input.sv
`timescale 1ns/1ps

`include "vic_params.svh"

module tb_vic_input
	import vic_pkg::*;
();

	// Six tests need well under 300 cycles after the 16 reset cycles
	localparam int TIMEOUT_CYCLES = 2000;

	logic        clk_sys;
	logic        rst;
	dl_bus_t     dl;
	joy_t        joy0;
	joy_t        joy1;
	logic [31:0] status;
	logic        user_reset;
	in_ports_t   ports;
	logic        coin;
	logic        landscape;
	logic [12:0] video_arx;
	logic [12:0] video_ary;
	logic        core_reset;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycle_count = 0;

	vic_input_top DUT (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.dl         (dl),
		.joy0       (joy0),
		.joy1       (joy1),
		.status     (status),
		.user_reset (user_reset),
		.ports      (ports),
		.coin       (coin),
		.landscape  (landscape),
		.video_arx  (video_arx),
		.video_ary  (video_ary),
		.core_reset (core_reset)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
		begin
			$display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// Drive helpers
	// ------------------------------------------------------------------

	// Land 1 ns after the n-th rising edge
	task automatic step(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	// Single-cycle strobe, download flag left at hold afterwards
	task automatic host_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data, input logic hold);
		dl.download = 1'b1;
		dl.wr = 1'b1;
		dl.index = index;
		dl.addr = addr;
		dl.data = data;
		step(1);
		dl.wr = 1'b0;
		dl.download = hold;
	endtask

	task automatic set_mode(input game_id_t game);
		host_write(`VIC_IDX_MODE, 25'd0, {3'b000, game}, 1'b0);
	endtask

	task automatic set_dip0(input dip_bank_t value);
		host_write(`VIC_IDX_DIP, 25'd0, value, 1'b0);
	endtask

	// ------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------

	task automatic check_ports(input in_ports_t got, input in_ports_t exp, input string name);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_byte(input port_byte_t got, input port_byte_t exp, input string name);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_ar(input logic [12:0] got, input logic [12:0] exp, input string name);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		if (errors == err_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d mismatches", name, errors - err_start);
	endtask

	// Digger P1 byte, start 1 from the first stick only
	function automatic port_byte_t digger_p1(joy_t j0, joy_t j1);
		joy_t j;
		j = j0 | j1;
		return ~{j[3], j[1], j[2], j[0], j[5], j[4], j[8], j0[7]};
	endfunction

	// Heiankyo P1 byte per the cabinet layout
	function automatic port_byte_t heiankyo_p1(logic p1_up, logic p1_fire1, logic p2_up,
		logic p2_fire1, logic dip_b0);
		return {2'b11, ~p1_fire1, ~p1_up, dip_b0, 1'b1, ~p2_fire1, ~p2_up};
	endfunction

	// Heiankyo P3 byte, down for each player
	function automatic port_byte_t heiankyo_p3(logic p1_down, logic p2_down);
		return {3'b110, ~p1_down, 3'b110, ~p2_down};
	endfunction

	// ------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------

	task automatic test_reset_rom();
		int e;
		e = errors;
		check_ports(ports, {4{`VIC_PORT_IDLE}}, "ports");
		check_bit(landscape, 1'b0, "landscape");
		check_bit(core_reset, 1'b1, "core_reset");
		check_ar(video_arx, 13'd7, "video_arx");
		check_ar(video_ary, 13'd8, "video_ary");
		// Blank ROM data never releases the core
		host_write(`VIC_IDX_ROM, 25'd0, 8'h00, 1'b0);
		step(2);
		check_bit(core_reset, 1'b1, "core_reset");
		// Core stays held while the transfer is still open
		host_write(`VIC_IDX_ROM, 25'd1, 8'hA5, 1'b1);
		step(2);
		check_bit(core_reset, 1'b1, "core_reset");
		dl.download = 1'b0;
		step(2);
		check_bit(core_reset, 1'b0, "core_reset");
		user_reset = 1'b1;
		step(1);
		check_bit(core_reset, 1'b1, "core_reset");
		user_reset = 1'b0;
		step(1);
		check_bit(core_reset, 1'b0, "core_reset");
		end_test("reset and rom load", e);
	endtask

	task automatic test_digger();
		int e;
		joy_t j_or;
		e = errors;
		set_mode(GAME_DIGGER);
		set_dip0(8'h02);
		for (int i = 0; i < 8; i++)
		begin
			joy0 = joy_t'($urandom);
			joy1 = joy_t'($urandom);
			step(1);
			j_or = joy0 | joy1;
			check_byte(ports.p1, digger_p1(joy0, joy1), "ports.p1");
			check_byte(ports.p2, `VIC_PORT_IDLE, "ports.p2");
			check_byte(ports.p3, {6'b111111, 2'b10}, "ports.p3");
			check_byte(ports.p4, `VIC_PORT_IDLE, "ports.p4");
			check_bit(coin, j_or[9], "coin");
		end
		end_test("digger", e);
	endtask

	task automatic test_landscape_games();
		int e;
		dip_bank_t d;
		joy_t j;
		e = errors;
		d = 8'h0A;
		// Right, down and fire 1
		joy0 = 12'h015;
		joy1 = 12'h000;
		j = joy0 | joy1;
		set_dip0(d);
		for (int g = 0; g < 2; g++)
		begin
			set_mode(g == 0 ? GAME_FROGS : GAME_HEADON);
			for (int h = 0; h < 2; h++)
			begin
				status[`VIC_ST_HORZ] = (h == 1);
				step(2);
				if (g == 0)
					check_byte(ports.p1, {~j[4], d[3], d[2], d[1], d[0], ~j[1], ~j[3], ~j[0]},
						"ports.p1");
				else
					check_byte(ports.p1, {~j[3], ~j[1], ~j[2], ~j[0], ~j[4], d[0], d[2:1]},
						"ports.p1");
				check_bit(landscape, 1'b1, "landscape");
				check_ar(video_arx, 13'd8, "video_arx");
				check_ar(video_ary, 13'd7, "video_ary");
			end
		end
		status = 32'd0;
		end_test("frogs and head on", e);
	endtask

	task automatic test_heiankyo();
		int e;
		e = errors;
		joy0 = 12'h000;
		// Up, down and fire 1 on the second stick only
		joy1 = 12'h01C;
		set_mode(GAME_HEIANKYO);
		set_dip0(8'h01);
		step(3);
		check_byte(ports.p1, heiankyo_p1(1'b1, 1'b1, 1'b1, 1'b1, 1'b1), "ports.p1");
		check_byte(ports.p3, heiankyo_p3(1'b1, 1'b1), "ports.p3");
		set_dip0(8'h00);
		step(3);
		check_byte(ports.p1, heiankyo_p1(1'b0, 1'b0, 1'b1, 1'b1, 1'b0), "ports.p1");
		check_byte(ports.p3, heiankyo_p3(1'b0, 1'b1), "ports.p3");
		joy1 = 12'h000;
		end_test("heiankyo", e);
	endtask

	task automatic test_space_attack();
		int e;
		e = errors;
		set_mode(GAME_SPACEATTACK);
		for (int i = 0; i < 4; i++)
		begin
			set_dip0({5'd0, 2'(i), 1'b0});
			step(1);
			check_byte(ports.p3, {1'b0, 2'b11, 1'b0, 3'(i + 3), 1'b0}, "ports.p3");
		end
		set_mode(game_id_t'(5'd9));
		step(1);
		check_ports(ports, {4{`VIC_PORT_IDLE}}, "ports");
		for (int a = 1; a < 4; a++)
		begin
			status[`VIC_ST_AR_LO +: 2] = 2'(a);
			step(1);
			check_ar(video_arx, 13'(a - 1), "video_arx");
			check_ar(video_ary, 13'd0, "video_ary");
		end
		status = 32'd0;
		end_test("space attack and aspect", e);
	endtask

	task automatic test_dip_range();
		int e;
		in_ports_t exp;
		e = errors;
		set_mode(GAME_DIGGER);
		set_dip0(8'h01);
		joy0 = 12'h003;
		exp = {digger_p1(joy0, joy1), `VIC_PORT_IDLE, {6'b111111, 2'b01}, `VIC_PORT_IDLE};
		// Address 8 lies above the bank range
		host_write(`VIC_IDX_DIP, 25'h8, 8'h02, 1'b0);
		step(3);
		check_ports(ports, exp, "ports");
		end_test("dip address range", e);
	endtask

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------

	initial
	begin
		void'($urandom(32'h5900f485));
		rst = 1'b1;
		dl = '0;
		joy0 = '0;
		joy1 = '0;
		status = 32'd0;
		user_reset = 1'b0;
		repeat (16) @(posedge clk_sys);
		#1;
		rst = 1'b0;

		test_reset_rom();
		test_digger();
		test_landscape_games();
		test_heiankyo();
		test_space_attack();
		test_dip_range();

		$display("tests %0d, checks %0d, failures %0d", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: vic_inputs.f
+incdir+common
common/vic_pkg.sv
src/download_ctrl.sv
port_map/player_router.sv
port_map/cabinet_mapper.sv
src/vic_input_top.sv
test/tb_vic_input.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the vic_inputs testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_vic_input \
	-f vic_inputs.f \
	--Mdir obj_dir -o tb_vic_input
if [ $? -ne 0 ]; then
	echo "run.sh: Verilator compile failed"
	exit 1
fi

./obj_dir/tb_vic_input > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "run.sh: simulation exited with status $sim_status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "run.sh: testbench reported failures"
	exit 1
fi

echo "run.sh: simulation passed"
exit 0
